//--- hw/isaPkg.sv
package isaPkg;

	// ============================================================
	// Word and field types
	// ============================================================
	typedef logic [15:0] word_t;
	typedef logic [1:0]  regIdx_t;
	typedef logic [3:0]  opcode_t;
	typedef logic [5:0]  func_t;
	typedef logic [7:0]  imm_t;
	typedef logic [11:0] target_t;

	localparam int numRegs = 4;
	localparam regIdx_t linkReg = 2'd2; // JAL and JRL write here

	// Field positions, widths follow the types above
	localparam int opLsb     = 12;
	localparam int rsLsb     = 10;
	localparam int rtLsb     = 8;
	localparam int rdLsb     = 6;
	localparam int fnLsb     = 0;
	localparam int immLsb    = 0;
	localparam int targetLsb = 0;

	// ============================================================
	// Opcodes
	// ============================================================
	localparam opcode_t opBne = 4'd0;
	localparam opcode_t opBeq = 4'd1;
	localparam opcode_t opBgz = 4'd2;
	localparam opcode_t opBlz = 4'd3;
	localparam opcode_t opAdi = 4'd4;
	localparam opcode_t opOri = 4'd5;
	localparam opcode_t opLhi = 4'd6;
	localparam opcode_t opLwd = 4'd7;
	localparam opcode_t opSwd = 4'd8;
	localparam opcode_t opJmp = 4'd9;
	localparam opcode_t opJal = 4'd10;
	localparam opcode_t opAlu = 4'd15; // R-type, func selects

	// ============================================================
	// R-type functions
	// ============================================================
	localparam func_t fnAdd = 6'd0;
	localparam func_t fnSub = 6'd1;
	localparam func_t fnAnd = 6'd2;
	localparam func_t fnOrr = 6'd3;
	localparam func_t fnNot = 6'd4;
	localparam func_t fnTcp = 6'd5;
	localparam func_t fnShl = 6'd6;
	localparam func_t fnShr = 6'd7;
	localparam func_t fnJpr = 6'd25;
	localparam func_t fnJrl = 6'd26;
	localparam func_t fnWwd = 6'd28;
	localparam func_t fnHlt = 6'd29;

endpackage

//--- hw/ctrlPkg.sv
package ctrlPkg;

	// ============================================================
	// Control encodings
	// ============================================================
	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluNot, aluTcp, aluShl, aluShr, aluPassB
	} aluOp_e;

	typedef enum logic [1:0] {pcPlus1, pcBranch, pcJump, pcReg} pcSrc_e;
	typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSel_e;
	typedef enum logic [1:0] {destRd, destRt, destLink} destSel_e;
	typedef enum logic [1:0] {brNe, brEq, brGz, brLz} brCond_e;
	typedef enum logic [1:0] {immSign, immZero, immHigh} immKind_e;

	typedef enum logic [2:0] {
		stFetch, stDecode, stExecute, stMemAccess, stWriteBack, stHalted
	} state_e;

	// ============================================================
	// Control bundles
	// ============================================================
	typedef struct packed {
		aluOp_e   aluOp;
		logic     aluSrcImm; // B operand is the extended immediate
		immKind_e immKind;
		pcSrc_e   pcSrc;
		logic     isBranch;
		brCond_e  brCond;
		logic     regWrite;
		destSel_e destSel;
		wbSel_e   wbSel;
		logic     memRead;
		logic     memWrite;
		logic     isWwd;
		logic     isHalt;
	} decodedCtrl_t;

	typedef struct packed {
		logic irLoad;      // Also advances the PC
		logic operandLoad;
		logic aluLoad;
		logic mdrLoad;
		logic pcLoad;      // Redirect from branch or jump
		logic rfWrite;
		logic wwdFire;
		logic addrFromAlu;
	} stepCtrl_t;

	localparam decodedCtrl_t nopCtrl = '{
		aluOp: aluAdd, aluSrcImm: 1'b0, immKind: immSign, pcSrc: pcPlus1,
		isBranch: 1'b0, brCond: brNe, regWrite: 1'b0, destSel: destRd,
		wbSel: wbAlu, memRead: 1'b0, memWrite: 1'b0, isWwd: 1'b0, isHalt: 1'b0
	};

	localparam stepCtrl_t stepIdle = '0;

endpackage

//--- hw/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input  isaPkg::word_t          instr,
	output ctrlPkg::decodedCtrl_t  ctrl
);

	isaPkg::opcode_t  opcode;
	isaPkg::func_t    func;
	ctrlPkg::aluOp_e  rOp;
	logic             rType;

	assign opcode = instr[isaPkg::opLsb +: $bits(isaPkg::opcode_t)];
	assign func   = instr[isaPkg::fnLsb +: $bits(isaPkg::func_t)];

	// Plain ALU functions of the R-type group
	always_comb begin
		rType = 1'b1;
		case (func)
			isaPkg::fnAdd: rOp = ctrlPkg::aluAdd;
			isaPkg::fnSub: rOp = ctrlPkg::aluSub;
			isaPkg::fnAnd: rOp = ctrlPkg::aluAnd;
			isaPkg::fnOrr: rOp = ctrlPkg::aluOr;
			isaPkg::fnNot: rOp = ctrlPkg::aluNot;
			isaPkg::fnTcp: rOp = ctrlPkg::aluTcp;
			isaPkg::fnShl: rOp = ctrlPkg::aluShl;
			isaPkg::fnShr: rOp = ctrlPkg::aluShr;
			default: begin
				rOp = ctrlPkg::aluAdd;
				rType = 1'b0;
			end
		endcase
	end

	always_comb begin
		ctrl = ctrlPkg::nopCtrl; // Undefined encodings stay inactive
		case (opcode)
			isaPkg::opAlu: begin
				if (rType) begin
					ctrl.aluOp = rOp;
					ctrl.regWrite = 1'b1;
					ctrl.destSel = ctrlPkg::destRd;
				end else begin
					case (func)
						isaPkg::fnJpr: ctrl.pcSrc = ctrlPkg::pcReg;
						isaPkg::fnJrl: begin
							ctrl.pcSrc = ctrlPkg::pcReg;
							ctrl.regWrite = 1'b1;
							ctrl.destSel = ctrlPkg::destLink;
							ctrl.wbSel = ctrlPkg::wbLink;
						end
						isaPkg::fnWwd: ctrl.isWwd = 1'b1;
						isaPkg::fnHlt: ctrl.isHalt = 1'b1;
						default: ;
					endcase
				end
			end
			isaPkg::opAdi, isaPkg::opOri, isaPkg::opLhi, isaPkg::opLwd: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.destSel = ctrlPkg::destRt;
				if (opcode == isaPkg::opOri) begin
					ctrl.aluOp = ctrlPkg::aluOr;
					ctrl.immKind = ctrlPkg::immZero;
				end else if (opcode == isaPkg::opLhi) begin
					ctrl.aluOp = ctrlPkg::aluPassB;
					ctrl.immKind = ctrlPkg::immHigh;
				end else if (opcode == isaPkg::opLwd) begin
					ctrl.wbSel = ctrlPkg::wbMem;
					ctrl.memRead = 1'b1;
				end
			end
			isaPkg::opSwd: begin
				ctrl.aluSrcImm = 1'b1; // Base plus signed offset
				ctrl.memWrite = 1'b1;
			end
			isaPkg::opBne, isaPkg::opBeq, isaPkg::opBgz, isaPkg::opBlz: begin
				ctrl.isBranch = 1'b1;
				ctrl.pcSrc = ctrlPkg::pcBranch;
				ctrl.brCond = ctrlPkg::brCond_e'(opcode[1:0]); // Opcodes 0..3 in order
			end
			isaPkg::opJmp: ctrl.pcSrc = ctrlPkg::pcJump;
			isaPkg::opJal: begin
				ctrl.pcSrc = ctrlPkg::pcJump;
				ctrl.regWrite = 1'b1;
				ctrl.destSel = ctrlPkg::destLink;
				ctrl.wbSel = ctrlPkg::wbLink;
			end
			default: ;
		endcase
	end

endmodule

//--- hw/cycleFsm.sv
`timescale 1ns/1ps

module cycleFsm (
	input  logic                  clk,
	input  logic                  rst,
	input  ctrlPkg::decodedCtrl_t ctrl,
	input  logic                  memReady,
	output ctrlPkg::stepCtrl_t    step,
	output logic                  memRead,
	output logic                  memWrite,
	output isaPkg::word_t         numInst,
	output logic                  halted
);

	ctrlPkg::state_e state;
	ctrlPkg::state_e nextState;
	logic            retire;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ctrlPkg::stFetch;
			numInst <= '0;
		end else begin
			state <= nextState;
			if (retire)
				numInst <= numInst + 16'd1;
		end
	end

	always_comb begin
		nextState = state;
		step = ctrlPkg::stepIdle;
		retire = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		case (state)
			ctrlPkg::stFetch: begin
				memRead = 1'b1;
				if (memReady) begin
					step.irLoad = 1'b1;
					nextState = ctrlPkg::stDecode;
				end
			end
			ctrlPkg::stDecode: begin
				step.operandLoad = 1'b1;
				nextState = ctrlPkg::stExecute;
			end
			ctrlPkg::stExecute: begin
				step.aluLoad = 1'b1;
				step.pcLoad = (ctrl.pcSrc != ctrlPkg::pcPlus1);
				step.wwdFire = ctrl.isWwd;
				if (ctrl.isHalt) begin
					retire = 1'b1;
					nextState = ctrlPkg::stHalted;
				end else if (ctrl.memRead || ctrl.memWrite) begin
					nextState = ctrlPkg::stMemAccess;
				end else if (ctrl.regWrite) begin
					nextState = ctrlPkg::stWriteBack;
				end else begin
					retire = 1'b1; // Branches, plain jumps, WWD, undefined
					nextState = ctrlPkg::stFetch;
				end
			end
			ctrlPkg::stMemAccess: begin
				step.addrFromAlu = 1'b1;
				memRead = ctrl.memRead;
				memWrite = ctrl.memWrite;
				if (memReady) begin
					step.mdrLoad = ctrl.memRead;
					if (ctrl.memWrite) begin
						retire = 1'b1;
						nextState = ctrlPkg::stFetch;
					end else begin
						nextState = ctrlPkg::stWriteBack;
					end
				end
			end
			ctrlPkg::stWriteBack: begin
				step.rfWrite = 1'b1;
				retire = 1'b1;
				nextState = ctrlPkg::stFetch;
			end
			default: nextState = ctrlPkg::stHalted; // Parked until reset
		endcase
	end

	assign halted = (state == ctrlPkg::stHalted);

endmodule

//--- hw/regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic            clk,
	input  logic            rst,
	input  isaPkg::regIdx_t rdAddrA,
	input  isaPkg::regIdx_t rdAddrB,
	input  logic            wrEn,
	input  isaPkg::regIdx_t wrAddr,
	input  isaPkg::word_t   wrData,
	output isaPkg::word_t   rdDataA,
	output isaPkg::word_t   rdDataB
);

	isaPkg::word_t regs [isaPkg::numRegs];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < isaPkg::numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Asynchronous read ports
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

//--- hw/alu.sv
`timescale 1ns/1ps

module alu (
	input  isaPkg::word_t    opA,
	input  isaPkg::word_t    opB,
	input  ctrlPkg::aluOp_e  op,
	input  ctrlPkg::brCond_e cond,
	output isaPkg::word_t    result,
	output logic             taken
);

	always_comb begin
		case (op)
			ctrlPkg::aluAdd:   result = opA + opB;
			ctrlPkg::aluSub:   result = opA - opB;
			ctrlPkg::aluAnd:   result = opA & opB;
			ctrlPkg::aluOr:    result = opA | opB;
			ctrlPkg::aluNot:   result = ~opA;
			ctrlPkg::aluTcp:   result = ~opA + 16'd1;
			ctrlPkg::aluShl:   result = {opA[14:0], 1'b0};
			ctrlPkg::aluShr:   result = {opA[15], opA[15:1]}; // Keeps the sign
			ctrlPkg::aluPassB: result = opB;
			default:           result = opA + opB;
		endcase
	end

	// Branch test on rs and rt, both signed
	always_comb begin
		case (cond)
			ctrlPkg::brNe: taken = (opA != opB);
			ctrlPkg::brEq: taken = (opA == opB);
			ctrlPkg::brGz: taken = ($signed(opA) > 16'sd0);
			ctrlPkg::brLz: taken = ($signed(opA) < 16'sd0);
			default:       taken = 1'b0;
		endcase
	end

endmodule

//--- hw/datapath.sv
`timescale 1ns/1ps

module datapath (
	input  logic                  clk,
	input  logic                  rst,
	input  ctrlPkg::decodedCtrl_t ctrl,
	input  ctrlPkg::stepCtrl_t    step,
	input  isaPkg::word_t         memRdata,
	output isaPkg::word_t         memAddr,
	output isaPkg::word_t         memWdata,
	output isaPkg::word_t         instr,
	output isaPkg::word_t         outPort
);

	isaPkg::word_t   pc;
	isaPkg::word_t   pcInc;
	isaPkg::word_t   linkPc;
	isaPkg::word_t   opA;
	isaPkg::word_t   opB;
	isaPkg::word_t   aluOut;
	isaPkg::word_t   mdr;
	isaPkg::word_t   rdDataA;
	isaPkg::word_t   rdDataB;
	isaPkg::word_t   immExt;
	isaPkg::word_t   aluB;
	isaPkg::word_t   aluResult;
	isaPkg::word_t   pcTarget;
	isaPkg::word_t   wrData;
	isaPkg::imm_t    imm;
	isaPkg::target_t target;
	isaPkg::regIdx_t rs;
	isaPkg::regIdx_t rt;
	isaPkg::regIdx_t rd;
	isaPkg::regIdx_t wrAddr;
	logic            taken;
	logic            redirect;

	// ============================================================
	// Instruction fields
	// ============================================================
	assign rs     = instr[isaPkg::rsLsb +: $bits(isaPkg::regIdx_t)];
	assign rt     = instr[isaPkg::rtLsb +: $bits(isaPkg::regIdx_t)];
	assign rd     = instr[isaPkg::rdLsb +: $bits(isaPkg::regIdx_t)];
	assign imm    = instr[isaPkg::immLsb +: $bits(isaPkg::imm_t)];
	assign target = instr[isaPkg::targetLsb +: $bits(isaPkg::target_t)];

	always_comb begin
		case (ctrl.immKind)
			ctrlPkg::immZero: immExt = {8'h00, imm};
			ctrlPkg::immHigh: immExt = {imm, 8'h00}; // LHI
			default:          immExt = {{8{imm[7]}}, imm};
		endcase
	end

	// ============================================================
	// Program counter
	// ============================================================
	assign pcInc = pc + 16'd1;

	always_comb begin
		case (ctrl.pcSrc)
			ctrlPkg::pcBranch: pcTarget = pc + immExt; // pc already holds PC+1
			ctrlPkg::pcJump:   pcTarget = {pc[15:12], target};
			ctrlPkg::pcReg:    pcTarget = opA;
			default:           pcTarget = pcInc;
		endcase
	end

	assign redirect = step.pcLoad && (!ctrl.isBranch || taken);

	always_ff @(posedge clk) begin
		if (rst)
			pc <= '0;
		else if (step.irLoad)
			pc <= pcInc;
		else if (redirect)
			pc <= pcTarget;
	end

	// ============================================================
	// Step registers and execution
	// ============================================================
	always_ff @(posedge clk) begin
		if (step.irLoad) begin
			instr <= memRdata;
			linkPc <= pcInc;
		end
		if (step.operandLoad) begin
			opA <= rdDataA;
			opB <= rdDataB;
		end
		if (step.aluLoad)
			aluOut <= aluResult;
		if (step.mdrLoad)
			mdr <= memRdata;
	end

	regFile rf (
		.clk     (clk),
		.rst     (rst),
		.rdAddrA (rs),
		.rdAddrB (rt),
		.wrEn    (step.rfWrite),
		.wrAddr  (wrAddr),
		.wrData  (wrData),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB)
	);

	assign aluB = ctrl.aluSrcImm ? immExt : opB;

	alu aluUnit (
		.opA    (opA),
		.opB    (aluB),
		.op     (ctrl.aluOp),
		.cond   (ctrl.brCond),
		.result (aluResult),
		.taken  (taken)
	);

	always_comb begin
		case (ctrl.destSel)
			ctrlPkg::destRd: wrAddr = rd;
			ctrlPkg::destRt: wrAddr = rt;
			default:         wrAddr = isaPkg::linkReg;
		endcase
		case (ctrl.wbSel)
			ctrlPkg::wbMem:  wrData = mdr;
			ctrlPkg::wbLink: wrData = linkPc;
			default:         wrData = aluOut;
		endcase
	end

	assign memAddr  = step.addrFromAlu ? aluOut : pc;
	assign memWdata = opB;  // SWD stores rt
	assign outPort  = opA;  // WWD shows rs

endmodule

//--- hw/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
	input  logic          clk,
	input  logic          rst,
	input  isaPkg::word_t memRdata,
	input  logic          memReady,
	output isaPkg::word_t memAddr,
	output logic          memRead,
	output logic          memWrite,
	output isaPkg::word_t memWdata,
	output isaPkg::word_t outPort,
	output logic          outValid,
	output isaPkg::word_t numInst,
	output logic          halted
);

	isaPkg::word_t         instr;
	ctrlPkg::decodedCtrl_t ctrl;
	ctrlPkg::stepCtrl_t    step;

	controlUnit decoder (
		.instr (instr),
		.ctrl  (ctrl)
	);

	cycleFsm fsm (
		.clk      (clk),
		.rst      (rst),
		.ctrl     (ctrl),
		.memReady (memReady),
		.step     (step),
		.memRead  (memRead),
		.memWrite (memWrite),
		.numInst  (numInst),
		.halted   (halted)
	);

	datapath dp (
		.clk      (clk),
		.rst      (rst),
		.ctrl     (ctrl),
		.step     (step),
		.memRdata (memRdata),
		.memAddr  (memAddr),
		.memWdata (memWdata),
		.instr    (instr),
		.outPort  (outPort)
	);

	assign outValid = step.wwdFire; // One pulse in execute

endmodule

//--- verif/memModel.sv
`timescale 1ns/1ps

module memModel (
	input  logic          clk,
	input  logic          rst,
	input  isaPkg::word_t memAddr,
	input  logic          memRead,
	input  logic          memWrite,
	input  isaPkg::word_t memWdata,
	output isaPkg::word_t memRdata,
	output logic          memReady
);

	localparam int depth = 1024;

	isaPkg::word_t mem [depth];
	int unsigned   seed = 32'h4d1a16b3;
	logic          busy;
	int            waitLeft;

	assign memRdata = mem[memAddr[9:0]]; // Valid in the ready cycle

	// ============================================================
	// Ready answers a held request after 1 to 4 cycles
	// ============================================================
	initial begin
		void'($urandom(seed));
		memReady <= 1'b0;
		busy = 1'b0;
		waitLeft = 0;
		forever begin
			@(posedge clk);
			if (memReady && memWrite && !rst)
				mem[memAddr[9:0]] = memWdata;
			if (rst || memReady) begin
				memReady <= 1'b0;
				busy = 1'b0;
			end else if (memRead || memWrite) begin
				if (!busy) begin
					busy = 1'b1;
					waitLeft = $urandom_range(4, 1) - 1;
				end else begin
					waitLeft = waitLeft - 1;
				end
				if (waitLeft == 0)
					memReady <= 1'b1;
			end
		end
	end

	task automatic loadProgram(input isaPkg::word_t image [$]);
		for (int i = 0; i < depth; i++)
			mem[i] = isaPkg::word_t'(i) ^ 16'hA55A; // Unused words differ per address
		for (int i = 0; i < image.size(); i++)
			mem[i] = image[i];
	endtask

	function automatic isaPkg::word_t readWord(input isaPkg::word_t addr);
		return mem[addr[9:0]];
	endfunction

endmodule

//--- verif/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

	localparam int cyclesPerInstr = 13; // Five states plus two worst-case waits
	localparam int resetCycles    = 5;
	localparam int haltWatch      = 20;
	localparam int runMargin      = 60;

	logic          clk;
	logic          rst;
	isaPkg::word_t memRdata;
	logic          memReady;
	isaPkg::word_t memAddr;
	logic          memRead;
	logic          memWrite;
	isaPkg::word_t memWdata;
	isaPkg::word_t outPort;
	logic          outValid;
	isaPkg::word_t numInst;
	logic          halted;

	isaPkg::word_t prog [$];
	isaPkg::word_t expOut [$];
	isaPkg::word_t gotOut [$];
	isaPkg::word_t wrAddrs [$];
	isaPkg::word_t wrWords [$];
	int            execCount;
	int            reqAfterHalt;
	int            cycleCount = 0;
	int            cycleLimit = 100;

	cpuTop UUT (
		.clk      (clk),
		.rst      (rst),
		.memRdata (memRdata),
		.memReady (memReady),
		.memAddr  (memAddr),
		.memRead  (memRead),
		.memWrite (memWrite),
		.memWdata (memWdata),
		.outPort  (outPort),
		.outValid (outValid),
		.numInst  (numInst),
		.halted   (halted)
	);

	memModel memory (
		.clk      (clk),
		.rst      (rst),
		.memAddr  (memAddr),
		.memRead  (memRead),
		.memWrite (memWrite),
		.memWdata (memWdata),
		.memRdata (memRdata),
		.memReady (memReady)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("Timeout after %0d cycles, the core did not halt in time", cycleCount);
			$display("Test failures found");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	// Outputs are sampled mid-cycle
	always @(negedge clk) begin
		if (!rst) begin
			if (outValid)
				gotOut.push_back(outPort);
			if (memWrite && memReady) begin
				wrAddrs.push_back(memAddr);
				wrWords.push_back(memWdata);
			end
			if (halted && (memRead || memWrite))
				reqAfterHalt++;
		end
	end

	// ============================================================
	// Checking and program building
	// ============================================================
	task automatic checkEq(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Mismatch in %s: expected %0h, actual %0h", testName, expected, actual);
			$display("Test failures found");
			$fatal(1, "Stopped at the first error");
		end
	endtask

	function automatic isaPkg::word_t encodeR(input isaPkg::func_t fn,
		input isaPkg::regIdx_t rs, input isaPkg::regIdx_t rt, input isaPkg::regIdx_t rd);
		return {isaPkg::opAlu, rs, rt, rd, fn};
	endfunction

	function automatic isaPkg::word_t encodeI(input isaPkg::opcode_t op,
		input isaPkg::regIdx_t rs, input isaPkg::regIdx_t rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic isaPkg::word_t encodeJ(input isaPkg::opcode_t op,
		input logic [11:0] target);
		return {op, target};
	endfunction

	task automatic newProgram();
		prog.delete();
		expOut.delete();
		execCount = 0;
	endtask

	task automatic addInstr(input isaPkg::word_t word, input bit executed);
		prog.push_back(word);
		if (executed)
			execCount++;
	endtask

	task automatic addWwd(input isaPkg::regIdx_t rs, input isaPkg::word_t expected);
		addInstr(encodeR(isaPkg::fnWwd, rs, 2'd0, 2'd0), 1'b1);
		expOut.push_back(expected);
	endtask

	task automatic addHalt();
		addInstr(encodeR(isaPkg::fnHlt, 2'd0, 2'd0, 2'd0), 1'b1);
	endtask

	// Marker is LHI r2 then WWD r2 and shows id in the high byte
	task automatic addMarker(input logic [7:0] id, input bit executed);
		addInstr(encodeI(isaPkg::opLhi, 2'd0, 2'd2, id), executed);
		addInstr(encodeR(isaPkg::fnWwd, 2'd2, 2'd0, 2'd0), executed);
		if (executed)
			expOut.push_back({id, 8'h00});
	endtask

	task automatic aluStep(input isaPkg::func_t fn, input isaPkg::regIdx_t rs,
		input isaPkg::regIdx_t rt, input isaPkg::word_t expected);
		addInstr(encodeR(fn, rs, rt, 2'd3), 1'b1);
		addWwd(2'd3, expected);
	endtask

	// Offset 2 skips the marker that follows
	task automatic addBranch(input isaPkg::opcode_t op, input isaPkg::regIdx_t rs,
		input isaPkg::regIdx_t rt, input bit taken, input logic [7:0] id);
		addInstr(encodeI(op, rs, rt, 8'd2), 1'b1);
		addMarker(id, !taken);
	endtask

	// ============================================================
	// Run control
	// ============================================================
	task automatic applyReset();
		@(posedge clk);
		rst <= 1'b1;
		repeat (resetCycles) @(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic startRun();
		memory.loadProgram(prog);
		gotOut.delete();
		wrAddrs.delete();
		wrWords.delete();
		reqAfterHalt = 0;
		cycleLimit = cycleCount + resetCycles + execCount * cyclesPerInstr + haltWatch + runMargin;
		applyReset();
	endtask

	task automatic finishRun(input string testName);
		while (!halted)
			@(negedge clk);
		repeat (haltWatch) @(negedge clk);
		@(posedge clk);
		checkEq(testName, 1, halted);
		checkEq(testName, 0, reqAfterHalt);
		checkEq(testName, execCount, numInst);
		checkEq(testName, expOut.size(), gotOut.size());
		foreach (expOut[i])
			checkEq(testName, expOut[i], gotOut[i]);
	endtask

	// ============================================================
	// Directed tests
	// ============================================================
	task automatic resetAndHaltTest();
		newProgram();
		addInstr(encodeI(isaPkg::opAdi, 2'd0, 2'd0, 8'd9), 1'b1);
		addWwd(2'd0, 16'd9);
		addHalt();
		addMarker(8'h77, 1'b0); // Past HLT and never fetched
		startRun();
		@(negedge clk);
		checkEq("reset state", 0, numInst);
		checkEq("reset state", 0, halted);
		checkEq("reset state", 0, outValid);
		checkEq("reset state", 0, memWrite);
		checkEq("reset state", 1, memRead);
		checkEq("reset state", 0, memAddr);
		finishRun("reset and halt");
	endtask

	task automatic aluTest();
		isaPkg::word_t a;
		isaPkg::word_t b;
		a = {8'h12, 8'h00} | {8'h00, 8'h34};
		b = ({8'hF0, 8'h00} | {8'h00, 8'h8F}) + {8'hFF, 8'hFD}; // ORI zero extends and ADI sign extends
		newProgram();
		addInstr(encodeI(isaPkg::opLhi, 2'd0, 2'd0, 8'h12), 1'b1);
		addInstr(encodeI(isaPkg::opOri, 2'd0, 2'd0, 8'h34), 1'b1);
		addInstr(encodeI(isaPkg::opLhi, 2'd1, 2'd1, 8'hF0), 1'b1);
		addInstr(encodeI(isaPkg::opOri, 2'd1, 2'd1, 8'h8F), 1'b1);
		addInstr(encodeI(isaPkg::opAdi, 2'd1, 2'd1, 8'hFD), 1'b1);
		addWwd(2'd0, a);
		addWwd(2'd1, b);
		aluStep(isaPkg::fnAdd, 2'd0, 2'd1, a + b);
		aluStep(isaPkg::fnSub, 2'd0, 2'd1, a - b);
		aluStep(isaPkg::fnAnd, 2'd0, 2'd1, a & b);
		aluStep(isaPkg::fnOrr, 2'd0, 2'd1, a | b);
		aluStep(isaPkg::fnNot, 2'd0, 2'd0, ~a);
		aluStep(isaPkg::fnTcp, 2'd0, 2'd0, 16'd0 - a);
		aluStep(isaPkg::fnShl, 2'd0, 2'd0, a << 1);
		aluStep(isaPkg::fnShr, 2'd1, 2'd0, $signed(b) >>> 1); // b is negative
		addHalt();
		startRun();
		finishRun("alu");
	endtask

	task automatic memoryTest();
		isaPkg::word_t base;
		isaPkg::word_t valA;
		isaPkg::word_t valB;
		base = 16'h0100;
		valA = 16'hBEEF;
		valB = 16'h1357;
		newProgram();
		addInstr(encodeI(isaPkg::opLhi, 2'd0, 2'd0, 8'h01), 1'b1);
		addInstr(encodeI(isaPkg::opLhi, 2'd0, 2'd1, 8'hBE), 1'b1);
		addInstr(encodeI(isaPkg::opOri, 2'd1, 2'd1, 8'hEF), 1'b1);
		addInstr(encodeI(isaPkg::opLhi, 2'd0, 2'd3, 8'h13), 1'b1);
		addInstr(encodeI(isaPkg::opOri, 2'd3, 2'd3, 8'h57), 1'b1);
		addInstr(encodeI(isaPkg::opSwd, 2'd0, 2'd1, 8'hFC), 1'b1); // base - 4
		addInstr(encodeI(isaPkg::opSwd, 2'd0, 2'd3, 8'h05), 1'b1); // base + 5
		addInstr(encodeI(isaPkg::opLwd, 2'd0, 2'd2, 8'hFC), 1'b1);
		addWwd(2'd2, valA);
		addInstr(encodeI(isaPkg::opLwd, 2'd0, 2'd2, 8'h05), 1'b1);
		addWwd(2'd2, valB);
		addHalt();
		startRun();
		finishRun("memory");
		checkEq("memory writes", 2, wrAddrs.size());
		checkEq("memory writes", base - 16'd4, wrAddrs[0]);
		checkEq("memory writes", valA, wrWords[0]);
		checkEq("memory writes", base + 16'd5, wrAddrs[1]);
		checkEq("memory writes", valB, wrWords[1]);
		checkEq("memory contents", valA, memory.readWord(base - 16'd4));
		checkEq("memory contents", valB, memory.readWord(base + 16'd5));
	endtask

	task automatic branchTest();
		newProgram();
		addInstr(encodeI(isaPkg::opAdi, 2'd0, 2'd0, 8'd5), 1'b1);   // r0 = 5
		addInstr(encodeI(isaPkg::opAdi, 2'd1, 2'd1, 8'd5), 1'b1);   // r1 = 5
		addInstr(encodeI(isaPkg::opAdi, 2'd3, 2'd3, 8'hFE), 1'b1);  // r3 = -2
		addBranch(isaPkg::opBne, 2'd0, 2'd1, 1'b0, 8'h10);
		addBranch(isaPkg::opBne, 2'd0, 2'd3, 1'b1, 8'h11);
		addBranch(isaPkg::opBeq, 2'd0, 2'd1, 1'b1, 8'h12);
		addBranch(isaPkg::opBeq, 2'd0, 2'd3, 1'b0, 8'h13);
		addBranch(isaPkg::opBgz, 2'd0, 2'd0, 1'b1, 8'h14);
		addBranch(isaPkg::opBgz, 2'd3, 2'd0, 1'b0, 8'h15);
		addBranch(isaPkg::opBlz, 2'd3, 2'd0, 1'b1, 8'h16);
		addBranch(isaPkg::opBlz, 2'd0, 2'd0, 1'b0, 8'h17);
		addMarker(8'h18, 1'b1);
		addHalt();
		startRun();
		finishRun("branches");
	endtask

	task automatic jumpTest();
		int here;
		newProgram();
		here = prog.size();
		addInstr(encodeJ(isaPkg::opJmp, 12'(here + 3)), 1'b1);
		addMarker(8'h51, 1'b0);
		here = prog.size();
		addInstr(encodeJ(isaPkg::opJal, 12'(here + 3)), 1'b1);
		addMarker(8'h52, 1'b0);
		addWwd(2'd2, isaPkg::word_t'(here + 1)); // Link is PC+1 of JAL
		here = prog.size();
		addInstr(encodeI(isaPkg::opAdi, 2'd1, 2'd1, 8'(here + 4)), 1'b1);
		addInstr(encodeR(isaPkg::fnJpr, 2'd1, 2'd0, 2'd0), 1'b1);
		addMarker(8'h53, 1'b0);
		addMarker(8'h54, 1'b1);
		here = prog.size();
		addInstr(encodeI(isaPkg::opAdi, 2'd3, 2'd3, 8'(here + 4)), 1'b1);
		addInstr(encodeR(isaPkg::fnJrl, 2'd3, 2'd0, 2'd0), 1'b1);
		addMarker(8'h55, 1'b0);
		addWwd(2'd2, isaPkg::word_t'(here + 2));
		addHalt();
		startRun();
		finishRun("jumps");
	endtask

	initial begin
		rst = 1'b1;
		resetAndHaltTest();
		aluTest();
		memoryTest();
		branchTest();
		jumpTest();
		$display("All tests passed!");
		$finish;
	end

endmodule

//--- sources.f
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/controlUnit.sv
hw/cycleFsm.sv
hw/regFile.sv
hw/alu.sv
hw/datapath.sv
hw/cpuTop.sv
verif/memModel.sv
verif/cpuTb.sv

//--- Bender.yml
package:
  name: cpu16

sources:
  - hw/isaPkg.sv
  - hw/ctrlPkg.sv
  - hw/controlUnit.sv
  - hw/cycleFsm.sv
  - hw/regFile.sv
  - hw/alu.sv
  - hw/datapath.sv
  - hw/cpuTop.sv
  - target: simulation
    files:
      - verif/memModel.sv
      - verif/cpuTb.sv
